// File: src/pdh_params.svh
`ifndef PDH_PARAMS_SVH
`define PDH_PARAMS_SVH

////////////////////////////////
// GPIO word layout
////////////////////////////////

`define PDH_GPIO_W       32
`define PDH_CMD_W        4
`define PDH_DATA_W       26
`define PDH_STROBE_BIT   30     // Rising edge of the command strobe latches

////////////////////////////////
// Converter widths
////////////////////////////////

`define PDH_ADC_W        14
`define PDH_DAC_W        14
`define PDH_ADC_OFFSET   8192   // Offset-binary midscale

// Power-up register values
`define PDH_DAC_RESET    14'h2000
`define PDH_COS_RESET    16'sh7FFF

`endif

// File: src/pdh_pkg.sv
`default_nettype none

`include "pdh_params.svh"

package pdh_pkg;

    // Command codes carried in GPIO bits 29..26
    typedef enum logic [`PDH_CMD_W-1:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6
    } cmd_t;

    // Latched command in the bit order of GPIO bits 29..0
    typedef struct packed {
        cmd_t                  cmd;
        logic [`PDH_DATA_W-1:0] data;
    } cmd_word_t;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t a;
        sample_t b;
    } adc_pair_t;

    typedef struct packed {
        sample_t cos_theta;
        sample_t sin_theta;
    } rot_coeffs_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    // Register state visible to readback
    typedef struct packed {
        logic [7:0]            led;
        logic [`PDH_DAC_W-1:0] dac1;
        logic [`PDH_DAC_W-1:0] dac2;
        rot_coeffs_t           staged;
        rot_coeffs_t           active;   // Pair used by the rotator
    } reg_view_t;

endpackage

`default_nettype wire

// File: src/cmd_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module cmd_capture (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`PDH_GPIO_W-1:0] gpio_i,
    output pdh_pkg::cmd_word_t     cmd_o
);

    import pdh_pkg::*;

    //////////////////////////////
    // GPIO synchronizer
    //////////////////////////////

    logic [`PDH_GPIO_W-1:0] sync1_r, sync2_r, sync3_r;
    logic                   strobe_prev_r;
    logic                   strobe_edge_w;
    cmd_word_t              cmd_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            sync1_r <= '0;
            sync2_r <= '0;
            sync3_r <= '0;
        end else begin
            sync1_r <= gpio_i;
            sync2_r <= sync1_r;
            sync3_r <= sync2_r;
        end
    end

    // Strobe rise on the third flop
    assign strobe_edge_w = sync3_r[`PDH_STROBE_BIT] & ~strobe_prev_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            strobe_prev_r <= 1'b0;
            cmd_r         <= '0;          // IDLE
        end else begin
            strobe_prev_r <= sync3_r[`PDH_STROBE_BIT];
            if (strobe_edge_w) begin
                cmd_r <= cmd_word_t'(sync3_r[$bits(cmd_word_t)-1:0]);
            end
        end
    end

    assign cmd_o = cmd_r;

endmodule

`default_nettype wire

// File: src/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module io_regs (
    input  logic                   clk,
    input  logic                   rst_i,
    input  pdh_pkg::cmd_word_t     cmd_i,
    output pdh_pkg::reg_view_t     view_o,
    output pdh_pkg::rot_coeffs_t   coeffs_o,
    output logic [7:0]             led_o,
    output logic [`PDH_DAC_W-1:0]  dac_dat_o,
    output logic                   dac_sel_o
);

    import pdh_pkg::*;

    reg_view_t view_r, view_w;
    logic      dac_sel_r;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    always_comb begin
        view_w = view_r;   // Hold unless written
        case (cmd_i.cmd)
            CMD_SET_LED: begin
                view_w.led = cmd_i.data[7:0];
            end

            CMD_SET_DAC: begin
                if (cmd_i.data[14]) begin
                    view_w.dac2 = cmd_i.data[`PDH_DAC_W-1:0];
                end else begin
                    view_w.dac1 = cmd_i.data[`PDH_DAC_W-1:0];
                end
            end

            CMD_SET_ROT_COEFFS: begin
                // Bit 16 picks sin over cos
                if (cmd_i.data[16]) begin
                    view_w.staged.sin_theta = sample_t'(cmd_i.data[15:0]);
                end else begin
                    view_w.staged.cos_theta = sample_t'(cmd_i.data[15:0]);
                end
            end

            CMD_COMMIT_ROT_COEFFS: begin
                view_w.active = view_r.staged;
            end

            default: begin
                // IDLE and readback commands write nothing
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            view_r.led              <= 8'd0;
            view_r.dac1             <= `PDH_DAC_RESET;
            view_r.dac2             <= `PDH_DAC_RESET;
            view_r.staged.cos_theta <= `PDH_COS_RESET;
            view_r.staged.sin_theta <= '0;
            view_r.active.cos_theta <= `PDH_COS_RESET;
            view_r.active.sin_theta <= '0;
        end else begin
            view_r <= view_w;
        end
    end

    //////////////////////////////
    // DAC interleave
    //////////////////////////////

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac_sel_r <= 1'b0;
        end else begin
            dac_sel_r <= ~dac_sel_r;
        end
    end

    assign dac_dat_o = dac_sel_r ? view_r.dac2 : view_r.dac1;
    assign dac_sel_o = dac_sel_r;

    assign view_o   = view_r;
    assign coeffs_o = view_r.active;
    assign led_o    = view_r.led;

endmodule

`default_nettype wire

// File: src/iq_rotator.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module iq_rotator (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [`PDH_ADC_W-1:0] adc_a_i,
    input  logic [`PDH_ADC_W-1:0] adc_b_i,
    input  pdh_pkg::rot_coeffs_t  coeffs_i,
    output pdh_pkg::adc_pair_t    adc_o,
    output pdh_pkg::iq_t          iq_o
);

    import pdh_pkg::*;

    // Offset-binary to signed by inversion around midscale
    function automatic sample_t to_signed(logic [`PDH_ADC_W-1:0] raw);
        return sample_t'(16'(`PDH_ADC_OFFSET) - 16'(raw));
    endfunction

    // Clamp to 32 bits, then scale by 2^-15
    function automatic sample_t sat_scale(logic signed [32:0] full);
        logic signed [31:0] sat;
        logic signed [31:0] shifted;
        if (full[32] != full[31]) begin
            sat = full[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
        end else begin
            sat = full[31:0];
        end
        shifted = sat >>> 15;
        return shifted[15:0];
    endfunction

    adc_pair_t         adc_w, adc_r;
    iq_t               iq_r;
    logic signed [32:0] i_full_w, q_full_w;

    assign adc_w.a = to_signed(adc_a_i);
    assign adc_w.b = to_signed(adc_b_i);

    always_comb begin
        i_full_w = $signed(coeffs_i.cos_theta) * $signed(adc_r.a)
                 - $signed(coeffs_i.sin_theta) * $signed(adc_r.b);
        q_full_w = $signed(coeffs_i.sin_theta) * $signed(adc_r.a)
                 + $signed(coeffs_i.cos_theta) * $signed(adc_r.b);
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            adc_r <= '0;
            iq_r  <= '0;
        end else begin
            adc_r  <= adc_w;                 // Cycle 1
            iq_r.i <= sat_scale(i_full_w);   // Cycle 2
            iq_r.q <= sat_scale(q_full_w);
        end
    end

    assign adc_o = adc_w;
    assign iq_o  = iq_r;

endmodule

`default_nettype wire

// File: src/readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module readback_mux (
    input  logic                      clk,
    input  logic                      rst_i,
    input  pdh_pkg::cmd_word_t        cmd_i,
    input  pdh_pkg::reg_view_t        view_i,
    input  logic [2*`PDH_ADC_W-1:0]   adc_raw_i,
    input  pdh_pkg::adc_pair_t        adc_i,
    input  pdh_pkg::iq_t              iq_i,
    output logic [`PDH_GPIO_W-1:0]    gpio_o
);

    import pdh_pkg::*;

    logic [`PDH_GPIO_W-1:0] cb_w, cb_r;
    logic [4:0]             sel_w;
    sample_t                signed_w;

    assign sel_w = cmd_i.data[4:0];

    //////////////////////////////
    // CHECK_SIGNED selector
    //////////////////////////////

    always_comb begin
        case (sel_w)
            5'd0:    signed_w = adc_i.a;
            5'd1:    signed_w = adc_i.b;
            5'd2:    signed_w = view_i.staged.cos_theta;
            5'd3:    signed_w = view_i.staged.sin_theta;
            5'd4:    signed_w = view_i.active.cos_theta;
            5'd5:    signed_w = view_i.active.sin_theta;
            5'd6:    signed_w = iq_i.i;
            5'd7:    signed_w = iq_i.q;
            default: signed_w = '0;
        endcase
    end

    // Command code always leads the word
    always_comb begin
        case (cmd_i.cmd)
            CMD_SET_LED: begin
                cb_w = {cmd_i.cmd, 20'd0, view_i.led};
            end
            CMD_SET_DAC: begin
                cb_w = {cmd_i.cmd, view_i.dac1, view_i.dac2};
            end
            CMD_GET_ADC: begin
                cb_w = {cmd_i.cmd, adc_raw_i};   // b high, a low
            end
            CMD_CHECK_SIGNED: begin
                cb_w = {cmd_i.cmd, 7'd0, sel_w, signed_w};
            end
            CMD_SET_ROT_COEFFS: begin
                cb_w = {cmd_i.cmd, view_i.staged.sin_theta[15:2],
                        view_i.staged.cos_theta[15:2]};
            end
            CMD_COMMIT_ROT_COEFFS: begin
                cb_w = {cmd_i.cmd, iq_i.q[15:2], iq_i.i[15:2]};
            end
            default: begin
                cb_w = '0;   // IDLE and unknown codes
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            cb_r <= '0;
        end else begin
            cb_r <= cb_w;
        end
    end

    assign gpio_o = cb_r;

endmodule

`default_nettype wire

// File: src/pdh_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module pdh_core (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`PDH_ADC_W-1:0]  adc_dat_a_i,
    input  logic [`PDH_ADC_W-1:0]  adc_dat_b_i,
    input  logic [`PDH_GPIO_W-1:0] gpio_i,
    output logic [`PDH_GPIO_W-1:0] gpio_o,
    output logic [7:0]             led_o,
    output logic [`PDH_DAC_W-1:0]  dac_dat_o,
    output logic                   dac_sel_o
);

    import pdh_pkg::*;

    cmd_word_t   cmd_w;
    reg_view_t   view_w;
    rot_coeffs_t coeffs_w;
    adc_pair_t   adc_w;
    iq_t         iq_w;

    cmd_capture u_cmd_capture (
        .clk   (clk),
        .rst_i (rst_i),
        .gpio_i(gpio_i),
        .cmd_o (cmd_w)
    );

    io_regs u_io_regs (
        .clk      (clk),
        .rst_i    (rst_i),
        .cmd_i    (cmd_w),
        .view_o   (view_w),
        .coeffs_o (coeffs_w),
        .led_o    (led_o),
        .dac_dat_o(dac_dat_o),
        .dac_sel_o(dac_sel_o)
    );

    iq_rotator u_iq_rotator (
        .clk     (clk),
        .rst_i   (rst_i),
        .adc_a_i (adc_dat_a_i),
        .adc_b_i (adc_dat_b_i),
        .coeffs_i(coeffs_w),
        .adc_o   (adc_w),
        .iq_o    (iq_w)
    );

    // Raw pair packed b over a for GET_ADC
    readback_mux u_readback_mux (
        .clk      (clk),
        .rst_i    (rst_i),
        .cmd_i    (cmd_w),
        .view_i   (view_w),
        .adc_raw_i({adc_dat_b_i, adc_dat_a_i}),
        .adc_i    (adc_w),
        .iq_i     (iq_w),
        .gpio_o   (gpio_o)
    );

endmodule

`default_nettype wire

// File: verification/pdh_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module pdh_props (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  dac_sel_i,
    input  logic [`PDH_ADC_W-1:0] adc_a_i,
    input  logic [`PDH_ADC_W-1:0] adc_b_i,
    input  pdh_pkg::rot_coeffs_t  coeffs_i,
    input  pdh_pkg::iq_t          iq_i
);

    import pdh_pkg::*;

    // Everything the rotator output depends on
    logic [2*`PDH_ADC_W+31:0] rot_in_w;

    assign rot_in_w = {adc_a_i, adc_b_i, coeffs_i};

    // DAC select alternates every cycle
    dac_sel_toggles: assert property (@(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> (dac_sel_i != $past(dac_sel_i)))
        else $error("dac_sel_o held its value for two cycles");

    // Two register stages between the inputs and iq_o
    iq_settles: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i, 1) && !$past(rst_i, 2) && !$past(rst_i, 3)
         && ($past(rot_in_w, 1) == $past(rot_in_w, 2))
         && ($past(rot_in_w, 2) == $past(rot_in_w, 3))) |-> $stable(iq_i))
        else $error("iq_o changed while its inputs were held");

endmodule

bind pdh_core pdh_props u_props (
    .clk      (clk),
    .rst_i    (rst_i),
    .dac_sel_i(dac_sel_o),
    .adc_a_i  (adc_dat_a_i),
    .adc_b_i  (adc_dat_b_i),
    .coeffs_i (coeffs_w),
    .iq_i     (iq_w)
);

`default_nettype wire

// File: verification/tb_pdh_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pdh_params.svh"

module tb_pdh_core;

    import pdh_pkg::*;

    localparam int CMD_CYCLES      = 12;   // Strobe low, strobe high, 10 to settle
    localparam int NUM_CMDS        = 80;
    localparam int WATCHDOG_CYCLES = 2 * NUM_CMDS * CMD_CYCLES + 80;
    localparam longint SAT_MAX     = 64'sh0000_0000_7FFF_FFFF;
    localparam longint SAT_MIN     = 64'shFFFF_FFFF_8000_0000;

    logic                   clk;
    logic                   rst_i;
    logic [`PDH_ADC_W-1:0]  adc_a;
    logic [`PDH_ADC_W-1:0]  adc_b;
    logic [`PDH_GPIO_W-1:0] gpio_i;
    logic [`PDH_GPIO_W-1:0] gpio_o;
    logic [7:0]             led_o;
    logic [`PDH_DAC_W-1:0]  dac_dat_o;
    logic                   dac_sel_o;
    logic [31:0]            rng_state;
    logic [15:0]            staged_cos;   // Expected staged pair
    logic [15:0]            staged_sin;

    pdh_core uut (
        .clk        (clk),
        .rst_i      (rst_i),
        .adc_dat_a_i(adc_a),
        .adc_dat_b_i(adc_b),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o),
        .led_o      (led_o),
        .dac_dat_o  (dac_dat_o),
        .dac_sel_o  (dac_sel_o)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] adc_model(input logic [13:0] raw);
        int v;
        v = `PDH_ADC_OFFSET - int'(raw);
        return v[15:0];
    endfunction

    function automatic logic [15:0] sat_shift_model(input longint acc);
        longint clamped;
        if (acc > SAT_MAX) begin
            clamped = SAT_MAX;
        end else if (acc < SAT_MIN) begin
            clamped = SAT_MIN;
        end else begin
            clamped = acc;
        end
        clamped = clamped >>> 15;
        return clamped[15:0];
    endfunction

    // Returns {i, q}
    function automatic logic [31:0] iq_model(input logic [15:0] c, input logic [15:0] s,
                                             input logic [13:0] raw_a, input logic [13:0] raw_b);
        longint cv;
        longint sv;
        longint av;
        longint bv;
        cv = longint'($signed(c));
        sv = longint'($signed(s));
        av = longint'($signed(adc_model(raw_a)));
        bv = longint'($signed(adc_model(raw_b)));
        return {sat_shift_model(cv * av - sv * bv), sat_shift_model(sv * av + cv * bv)};
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift(rng_state);
        r = rng_state;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("error %s exp %h got %h", name, exp, got);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Testbench failed");
            $fatal(1, "check failed");
        end
    endtask

    //////////////////////////////
    // Command helpers
    //////////////////////////////

    task automatic send_cmd(input logic [3:0] code, input logic [25:0] data);
        gpio_i = {2'b00, code, data};
        next_cycle();
        gpio_i = {2'b01, code, data};   // Strobe rise
        repeat (10) next_cycle();
    endtask

    task automatic check_signed(input logic [4:0] sel, input logic [15:0] exp);
        send_cmd(CMD_CHECK_SIGNED, {21'd0, sel});
        check_value("gpio_o", {4'd4, 7'd0, sel, exp}, gpio_o);
    endtask

    task automatic stage_coeffs(input logic [15:0] c, input logic [15:0] s);
        send_cmd(CMD_SET_ROT_COEFFS, {9'd0, 1'b0, c});
        check_value("gpio_o", {4'd5, staged_sin[15:2], c[15:2]}, gpio_o);
        send_cmd(CMD_SET_ROT_COEFFS, {9'd0, 1'b1, s});
        check_value("gpio_o", {4'd5, s[15:2], c[15:2]}, gpio_o);
        staged_cos = c;
        staged_sin = s;
    endtask

    task automatic commit_coeffs();
        logic [31:0] iq;
        send_cmd(CMD_COMMIT_ROT_COEFFS, 26'd0);
        iq = iq_model(staged_cos, staged_sin, adc_a, adc_b);
        check_value("gpio_o", {4'd6, iq[15:2], iq[31:18]}, gpio_o);   // Q over I
    endtask

    task automatic check_dac_phases(input logic [13:0] d1, input logic [13:0] d2);
        logic prev_sel;
        prev_sel = dac_sel_o;
        repeat (4) begin
            check_value("dac_dat_o", {18'd0, (dac_sel_o ? d2 : d1)}, {18'd0, dac_dat_o});
            next_cycle();
            check_true(dac_sel_o != prev_sel, "dac_sel_o did not toggle between cycles");
            prev_sel = dac_sel_o;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_reset();
        check_value("gpio_o", 32'd0, gpio_o);
        check_value("led_o", 32'd0, {24'd0, led_o});
        check_value("dac_sel_o", 32'd0, {31'd0, dac_sel_o});
        check_dac_phases(`PDH_DAC_RESET, `PDH_DAC_RESET);
    endtask

    task automatic test_led();
        logic [31:0] r;
        logic [7:0]  led;
        draw_random(r);
        led = r[7:0];
        send_cmd(CMD_SET_LED, {18'd0, led});
        check_value("led_o", {24'd0, led}, {24'd0, led_o});
        check_value("gpio_o", {4'd1, 20'd0, led}, gpio_o);
    endtask

    task automatic test_dac();
        logic [31:0] r;
        logic [13:0] d1;
        logic [13:0] d2;
        draw_random(r);
        d1 = r[13:0];
        d2 = r[27:14];
        send_cmd(CMD_SET_DAC, {11'd0, 1'b0, d1});
        send_cmd(CMD_SET_DAC, {11'd0, 1'b1, d2});
        check_value("gpio_o", {4'd2, d1, d2}, gpio_o);
        check_dac_phases(d1, d2);
    endtask

    task automatic test_adc();
        logic [31:0] r;
        for (int n = 0; n < 6; n++) begin
            draw_random(r);
            if (n == 0) begin
                adc_a = 14'd0;
                adc_b = 14'h3FFF;
            end else if (n == 1) begin
                adc_a = 14'h3FFF;
                adc_b = 14'd0;
            end else begin
                adc_a = r[13:0];
                adc_b = r[29:16];
            end
            send_cmd(CMD_GET_ADC, 26'd0);
            check_value("gpio_o", {4'd3, adc_b, adc_a}, gpio_o);
            check_signed(5'd0, adc_model(adc_a));
            check_signed(5'd1, adc_model(adc_b));
        end
    endtask

    task automatic test_coeffs();
        logic [31:0] r;
        draw_random(r);
        stage_coeffs(r[15:0], r[31:16]);
        check_signed(5'd2, staged_cos);
        check_signed(5'd3, staged_sin);
        check_signed(5'd4, 16'h7FFF);   // Active still at reset
        check_signed(5'd5, 16'h0000);
        commit_coeffs();
        check_signed(5'd4, staged_cos);
        check_signed(5'd5, staged_sin);
    endtask

    task automatic test_rotation();
        logic [31:0] r;
        logic [31:0] iq;
        logic [15:0] c;
        logic [15:0] s;
        for (int n = 0; n < 4; n++) begin
            draw_random(r);
            if (n == 3) begin
                // Full-scale coefficients, opposite ADC extremes
                adc_a = 14'd0;
                adc_b = 14'h3FFF;
                c = 16'h8000;
                s = 16'h8000;
            end else begin
                adc_a = r[13:0];
                adc_b = r[27:14];
                draw_random(r);
                c = r[15:0];
                s = r[31:16];
            end
            stage_coeffs(c, s);
            commit_coeffs();
            iq = iq_model(c, s, adc_a, adc_b);
            check_signed(5'd6, iq[31:16]);
            check_signed(5'd7, iq[15:0]);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        clk        = 1'b0;
        rst_i      = 1'b1;
        adc_a      = 14'h2000;   // Midscale
        adc_b      = 14'h2000;
        gpio_i     = '0;
        rng_state  = 32'h497986cd;
        staged_cos = `PDH_COS_RESET;
        staged_sin = 16'h0000;
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;

        test_reset();
        test_led();
        test_dac();
        test_adc();
        test_coeffs();
        test_rotation();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/pdh_pkg.sv
src/cmd_capture.sv
src/io_regs.sv
src/iq_rotator.sv
src/readback_mux.sv
src/pdh_core.sv
verification/pdh_props.sv
verification/tb_pdh_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sim.f \
        --top-module tb_pdh_core -o tb_pdh_core \
    && ./obj_dir/tb_pdh_core \
    || exit 1
